//--- verilog/turf_pkg.sv
package turf_pkg;

  // 160x120 frame buffer geometry
  localparam int X_W = 8;
  localparam int Y_W = 7;
  localparam int ADDR_W = X_W + Y_W;  // Clear scan address {x, y}

  localparam logic [Y_W-1:0] TIMER_ROW = 7'd119;

  // 3-bit RGB as the frame buffer stores it
  typedef enum logic [2:0] {
    black  = 3'b000,
    blue   = 3'b001,
    green  = 3'b010,
    red    = 3'b100,
    yellow = 3'b110,
    white  = 3'b111
  } colour_t;

  typedef enum logic [3:0] {
    start,
    clear_plot,
    clear_wait,
    clear_inc,
    draw_p1,
    draw_p2,
    draw_p3,
    draw_p4,
    draw_timer,
    game_end
  } game_state_t;

endpackage

//--- verilog/game_control.sv
module game_control
  import turf_pkg::*;
(
  input  logic CLOCK_50,
  input  logic arst_n,
  input  logic space_pressed,
  input  logic running,
  input  logic wait_done,
  input  logic scan_done,
  output logic ld_p1,
  output logic ld_p2,
  output logic ld_p3,
  output logic ld_p4,
  output logic ld_timer,
  output logic clear_plot,
  output logic clear_wait,
  output logic clear_inc,
  output logic clear_black,
  output logic game_started,
  output logic game_over
);

  game_state_t state;
  game_state_t next_state;
  logic        in_clear;

  // Clear states are shared by the opening and the closing clear
  assign in_clear = (state == turf_pkg::clear_plot) ||
                    (state == turf_pkg::clear_wait) ||
                    (state == turf_pkg::clear_inc);

  assign clear_black = in_clear && !game_started;

  always_comb
  begin
    next_state = state;
    case (state)
      start:
        if (space_pressed)
          next_state = turf_pkg::clear_plot;
      turf_pkg::clear_plot:
        next_state = turf_pkg::clear_wait;
      turf_pkg::clear_wait:
        if (wait_done)
          next_state = turf_pkg::clear_inc;
      turf_pkg::clear_inc:
      begin
        if (!scan_done)
          next_state = turf_pkg::clear_plot;
        else if (clear_black)
          next_state = draw_p1;  // Opening clear finished
        else
          next_state = game_end;
      end
      draw_p1:
        next_state = draw_p2;
      draw_p2:
        next_state = draw_p3;
      draw_p3:
        next_state = draw_p4;
      draw_p4:
        next_state = draw_timer;
      draw_timer:
        // Wipe the board white once time is up
        next_state = running ? draw_p1 : turf_pkg::clear_plot;
      game_end:
        next_state = game_end;
      default:
        next_state = start;
    endcase
  end

  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= start;
    end
    else
    begin
      state <= next_state;
    end
  end

  // Play flag set on the first round and never cleared
  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      game_started <= 1'b0;
    end
    else if (next_state == draw_p1)
    begin
      game_started <= 1'b1;
    end
  end

  assign ld_p1      = (state == draw_p1);
  assign ld_p2      = (state == draw_p2);
  assign ld_p3      = (state == draw_p3);
  assign ld_p4      = (state == draw_p4);
  assign ld_timer   = (state == draw_timer);
  assign clear_plot = (state == turf_pkg::clear_plot);
  assign clear_wait = (state == turf_pkg::clear_wait);
  assign clear_inc  = (state == turf_pkg::clear_inc);
  assign game_over  = (state == game_end);

endmodule

//--- verilog/plot_datapath.sv
module plot_datapath
  import turf_pkg::*;
#(
  parameter int SCREEN_W   = 160,
  parameter int CLEAR_WAIT = 7000
)
(
  input  logic           CLOCK_50,
  input  logic           arst_n,
  input  logic           ld_p1,
  input  logic           ld_p2,
  input  logic           ld_p3,
  input  logic           ld_p4,
  input  logic           ld_timer,
  input  logic           clear_plot,
  input  logic           clear_wait,
  input  logic           clear_inc,
  input  logic           clear_black,
  input  logic [X_W-1:0] p1_x,
  input  logic [Y_W-1:0] p1_y,
  input  logic [X_W-1:0] p2_x,
  input  logic [Y_W-1:0] p2_y,
  input  logic [X_W-1:0] p3_x,
  input  logic [Y_W-1:0] p3_y,
  input  logic [X_W-1:0] p4_x,
  input  logic [Y_W-1:0] p4_y,
  input  logic [X_W-1:0] timer_x,
  output logic           plot,
  output logic [X_W-1:0] x,
  output logic [Y_W-1:0] y,
  output colour_t        colour,
  output logic           wait_done,
  output logic           scan_done
);

  localparam int WAIT_W = $clog2(CLEAR_WAIT + 1);

  logic [ADDR_W-1:0] scan_addr;
  logic [ADDR_W-1:0] scan_next;
  logic [WAIT_W-1:0] wait_cnt;

  assign scan_next = scan_addr + 1'b1;

  // Last pixel of the scan is the one whose successor leaves the screen
  assign scan_done = (scan_next[ADDR_W-1:Y_W] == X_W'(SCREEN_W));
  assign wait_done = (wait_cnt == '0);

  // Registered pixel one cycle behind its load strobe
  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      plot   <= 1'b0;
      x      <= '0;
      y      <= '0;
      colour <= black;
    end
    else
    begin
      plot <= ld_p1 | ld_p2 | ld_p3 | ld_p4 | ld_timer | clear_plot;
      if (ld_p1)
      begin
        x      <= p1_x;
        y      <= p1_y;
        colour <= blue;
      end
      else if (ld_p2)
      begin
        x      <= p2_x;
        y      <= p2_y;
        colour <= green;
      end
      else if (ld_p3)
      begin
        x      <= p3_x;
        y      <= p3_y;
        colour <= red;
      end
      else if (ld_p4)
      begin
        x      <= p4_x;
        y      <= p4_y;
        colour <= yellow;
      end
      else if (ld_timer)
      begin
        x      <= timer_x;
        y      <= TIMER_ROW;  // Bottom row
        colour <= white;
      end
      else if (clear_plot)
      begin
        x      <= scan_addr[ADDR_W-1:Y_W];
        y      <= scan_addr[Y_W-1:0];
        colour <= clear_black ? black : white;
      end
    end
  end

  // Scan address rewinds on every round so the closing clear starts at 0
  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      scan_addr <= '0;
    end
    else if (ld_p1)
    begin
      scan_addr <= '0;
    end
    else if (clear_inc)
    begin
      scan_addr <= scan_next;
    end
  end

  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wait_cnt <= '0;
    end
    else if (clear_plot)
    begin
      wait_cnt <= WAIT_W'(CLEAR_WAIT - 1);  // Zero on the last wait cycle
    end
    else if (clear_wait && !wait_done)
    begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

endmodule

//--- verilog/game_timer.sv
module game_timer
  import turf_pkg::*;
#(
  parameter int TIMER_DIV = 2_500_000,
  parameter int TIMER_END = 158
)
(
  input  logic           CLOCK_50,
  input  logic           arst_n,
  input  logic           game_started,
  output logic [X_W-1:0] timer_x,
  output logic           running
);

  localparam int DIV_W = $clog2(TIMER_DIV + 1);

  logic [DIV_W-1:0] div_cnt;
  logic             tick;

  assign tick = game_started && (div_cnt == DIV_W'(TIMER_DIV - 1));

  // Tick divider in place of a second clock domain
  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
      div_cnt <= '0;
    else if (tick)
      div_cnt <= '0;
    else if (game_started)
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      timer_x <= '0;
      running <= 1'b1;
    end
    else if (tick && running)
    begin
      timer_x <= timer_x + 1'b1;
      if (timer_x >= X_W'(TIMER_END))
        running <= 1'b0;  // Column frozen from here on
    end
  end

endmodule

//--- verilog/turf_top.sv
module turf_top
  import turf_pkg::*;
#(
  parameter int SCREEN_W   = 160,
  parameter int CLEAR_WAIT = 7000,
  parameter int TIMER_DIV  = 2_500_000,
  parameter int TIMER_END  = 158
)
(
  input  logic           CLOCK_50,
  input  logic           arst_n,
  input  logic           space_pressed,
  input  logic [X_W-1:0] p1_x,
  input  logic [X_W-1:0] p2_x,
  input  logic [X_W-1:0] p3_x,
  input  logic [X_W-1:0] p4_x,
  input  logic [Y_W-1:0] p1_y,
  input  logic [Y_W-1:0] p2_y,
  input  logic [Y_W-1:0] p3_y,
  input  logic [Y_W-1:0] p4_y,
  output logic           plot,
  output logic [X_W-1:0] x,
  output logic [Y_W-1:0] y,
  output colour_t        colour,
  output logic           game_started,
  output logic           running,
  output logic           game_over
);

  logic           ld_p1;
  logic           ld_p2;
  logic           ld_p3;
  logic           ld_p4;
  logic           ld_timer;
  logic           clear_plot;
  logic           clear_wait;
  logic           clear_inc;
  logic           clear_black;
  logic           wait_done;
  logic           scan_done;
  logic [X_W-1:0] timer_x;

  game_control u_control (
    .CLOCK_50     (CLOCK_50),
    .arst_n       (arst_n),
    .space_pressed(space_pressed),
    .running      (running),
    .wait_done    (wait_done),
    .scan_done    (scan_done),
    .ld_p1        (ld_p1),
    .ld_p2        (ld_p2),
    .ld_p3        (ld_p3),
    .ld_p4        (ld_p4),
    .ld_timer     (ld_timer),
    .clear_plot   (clear_plot),
    .clear_wait   (clear_wait),
    .clear_inc    (clear_inc),
    .clear_black  (clear_black),
    .game_started (game_started),
    .game_over    (game_over)
  );

  plot_datapath #(
    .SCREEN_W  (SCREEN_W),
    .CLEAR_WAIT(CLEAR_WAIT)
  ) u_datapath (
    .CLOCK_50   (CLOCK_50),
    .arst_n     (arst_n),
    .ld_p1      (ld_p1),
    .ld_p2      (ld_p2),
    .ld_p3      (ld_p3),
    .ld_p4      (ld_p4),
    .ld_timer   (ld_timer),
    .clear_plot (clear_plot),
    .clear_wait (clear_wait),
    .clear_inc  (clear_inc),
    .clear_black(clear_black),
    .p1_x       (p1_x),
    .p1_y       (p1_y),
    .p2_x       (p2_x),
    .p2_y       (p2_y),
    .p3_x       (p3_x),
    .p3_y       (p3_y),
    .p4_x       (p4_x),
    .p4_y       (p4_y),
    .timer_x    (timer_x),
    .plot       (plot),
    .x          (x),
    .y          (y),
    .colour     (colour),
    .wait_done  (wait_done),
    .scan_done  (scan_done)
  );

  game_timer #(
    .TIMER_DIV(TIMER_DIV),
    .TIMER_END(TIMER_END)
  ) u_timer (
    .CLOCK_50    (CLOCK_50),
    .arst_n      (arst_n),
    .game_started(game_started),
    .timer_x     (timer_x),
    .running     (running)
  );

endmodule

//--- bench/turf_properties.sv
module turf_properties
  import turf_pkg::*;
#(
  parameter int SCREEN_W   = 160,
  parameter int CLEAR_WAIT = 7000,
  parameter int TIMER_END  = 158
)
(
  input logic           CLOCK_50,
  input logic           arst_n,
  input logic           space_pressed,
  input logic           clear_plot,
  input logic [X_W-1:0] timer_x,
  input logic [X_W-1:0] p1_x,
  input logic [X_W-1:0] p2_x,
  input logic [X_W-1:0] p3_x,
  input logic [X_W-1:0] p4_x,
  input logic [Y_W-1:0] p1_y,
  input logic [Y_W-1:0] p2_y,
  input logic [Y_W-1:0] p3_y,
  input logic [Y_W-1:0] p4_y,
  input logic           plot,
  input logic [X_W-1:0] x,
  input logic [Y_W-1:0] y,
  input colour_t        colour,
  input logic           game_started,
  input logic           running,
  input logic           game_over
);

  logic           space_seen;
  logic           clear_hit;     // Output pixel came from the clear scan
  logic           after_yellow;  // Next plot is the timer pixel
  logic           played;        // First blue plot seen
  logic [X_W-1:0] exp_x;
  logic [Y_W-1:0] exp_y;
  logic [X_W-1:0] last_tx;
  logic [X_W-1:0] px_q [4];
  logic [Y_W-1:0] py_q [4];
  logic [1:0]     pidx;

  assign pidx = (colour == blue) ? 2'd0 : (colour == green) ? 2'd1 :
                (colour == red) ? 2'd2 : 2'd3;

  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      space_seen   <= 1'b0;
      clear_hit    <= 1'b0;
      after_yellow <= 1'b0;
      played       <= 1'b0;
      exp_x        <= '0;
      exp_y        <= '0;
      last_tx      <= '0;
      px_q         <= '{default: '0};
      py_q         <= '{default: '0};
    end
    else
    begin
      space_seen   <= space_seen | space_pressed;
      clear_hit    <= clear_plot;
      after_yellow <= plot && (colour == yellow);
      played       <= played | (plot && (colour == blue));
      px_q         <= '{p1_x, p2_x, p3_x, p4_x};  // Inputs as the load saw them
      py_q         <= '{p1_y, p2_y, p3_y, p4_y};
      if (after_yellow && plot)
        last_tx <= x;
      if (plot && (colour == blue) && !played)
      begin
        exp_x <= '0;  // Closing clear starts over at (0,0)
        exp_y <= '0;
      end
      else if (clear_hit)
      begin
        exp_y <= exp_y + 1'b1;
        if (&exp_y)
          exp_x <= exp_x + 1'b1;  // Column done after row 127
      end
    end
  end

  a_idle: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    !space_seen |-> !plot && !game_started && !game_over)
    else
    begin
      $error("Plot or game flag raised before space at %0t", $time);
      turf_tb.errors++;
    end

  a_clear: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    clear_hit |-> plot && colour == (played ? white : black) && x == exp_x && y == exp_y)
    else
    begin
      $error("Mismatch at %0t: clear x,y,colour got (%0d,%0d,%0d) expected (%0d,%0d,%0d)",
             $time, $sampled(x), $sampled(y), $sampled(colour), $sampled(exp_x),
             $sampled(exp_y), $sampled(played) ? white : black);
      turf_tb.errors++;
    end

  a_clear_gap: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    clear_hit && !played |=> !plot [*CLEAR_WAIT+1] ##1 plot)
    else
    begin
      $error("Opening clear plots badly spaced at %0t", $time);
      turf_tb.errors++;
    end

  a_scan_full: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    $rose(game_started) || $rose(game_over) |-> exp_x == X_W'(SCREEN_W) && exp_y == '0)
    else
    begin
      $error("Mismatch at %0t: scan end x,y got (%0d,%0d) expected (%0d,0)",
             $time, $sampled(exp_x), $sampled(exp_y), SCREEN_W);
      turf_tb.errors++;
    end

  a_round: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    plot && colour == blue |=> plot && colour == green ##1 plot && colour == red
      ##1 plot && colour == yellow ##1 plot && colour == white && y == TIMER_ROW)
    else
    begin
      $error("Play round out of order at %0t", $time);
      turf_tb.errors++;
    end

  a_player: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    plot && colour inside {blue, green, red, yellow} |-> x == px_q[pidx] && y == py_q[pidx])
    else
    begin
      $error("Mismatch at %0t: player %0d x,y got (%0d,%0d) expected (%0d,%0d)",
             $time, $sampled(pidx) + 1, $sampled(x), $sampled(y),
             $sampled(px_q[pidx]), $sampled(py_q[pidx]));
      turf_tb.errors++;
    end

  a_timer_step: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    after_yellow && plot |-> x >= last_tx && x <= last_tx + 1)
    else
    begin
      $error("Mismatch at %0t: timer x got %0d expected %0d or %0d",
             $time, $sampled(x), $sampled(last_tx), $sampled(last_tx) + 1);
      turf_tb.errors++;
    end

  a_running: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    $fell(running) |-> $past(timer_x) >= TIMER_END)
    else
    begin
      $error("Running fell before the timer end column at %0t", $time);
      turf_tb.errors++;
    end

  a_final: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
    game_over |-> !plot ##1 game_over)
    else
    begin
      $error("Plot or game_over drop after game end at %0t", $time);
      turf_tb.errors++;
    end

endmodule

//--- bench/turf_tb.sv
module turf_tb
  import turf_pkg::*;
();

  localparam int SCREEN_W        = 2;
  localparam int CLEAR_WAIT      = 2;
  localparam int TIMER_DIV       = 8;
  localparam int TIMER_END       = 6;
  localparam int WATCHDOG_CYCLES = 2 * (2 * 256 * 4 + 200 * 8);

  logic           CLOCK_50;
  logic           arst_n;
  logic           space_pressed;
  logic [X_W-1:0] p1_x;
  logic [X_W-1:0] p2_x;
  logic [X_W-1:0] p3_x;
  logic [X_W-1:0] p4_x;
  logic [Y_W-1:0] p1_y;
  logic [Y_W-1:0] p2_y;
  logic [Y_W-1:0] p3_y;
  logic [Y_W-1:0] p4_y;
  logic           plot;
  logic [X_W-1:0] x;
  logic [Y_W-1:0] y;
  colour_t        colour;
  logic           game_started;
  logic           running;
  logic           game_over;

  int          errors = 0;  // Bumped by the bound assertions too
  int          plots = 0;
  int          rounds = 0;
  logic [31:0] lfsr;

  turf_top #(
    .SCREEN_W  (SCREEN_W),
    .CLEAR_WAIT(CLEAR_WAIT),
    .TIMER_DIV (TIMER_DIV),
    .TIMER_END (TIMER_END)
  ) DUT (.*);

  bind turf_top turf_properties #(
    .SCREEN_W  (SCREEN_W),
    .CLEAR_WAIT(CLEAR_WAIT),
    .TIMER_END (TIMER_END)
  ) u_props (.*);

  // Galois LFSR on x^32 + x^22 + x^2 + x + 1
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      value = {value[6:0], lfsr[0]};
    end
    return value;
  endfunction

  task automatic move_players();
    p1_x = take_bits(X_W);
    p1_y = Y_W'(take_bits(Y_W));
    p2_x = take_bits(X_W);
    p2_y = Y_W'(take_bits(Y_W));
    p3_x = take_bits(X_W);
    p3_y = Y_W'(take_bits(Y_W));
    p4_x = take_bits(X_W);
    p4_y = Y_W'(take_bits(Y_W));
  endtask

  initial
  begin
    CLOCK_50 = 1'b0;
    forever #20 CLOCK_50 = ~CLOCK_50;
  end

  initial
  begin
    logic timer_seen;
    logic prev_yellow;
    timer_seen    = 1'b0;
    prev_yellow   = 1'b0;
    arst_n        = 1'b0;
    space_pressed = 1'b0;
    lfsr          = 32'h094dc982;
    move_players();
    repeat (4) @(posedge CLOCK_50);
    #2 arst_n = 1'b1;
    repeat (6) @(posedge CLOCK_50);  // Idle on the start screen
    #2 space_pressed = 1'b1;
    @(posedge CLOCK_50);
    #2 space_pressed = 1'b0;
    while (!game_over)
    begin
      @(posedge CLOCK_50);
      #2;
      if (timer_seen)
        move_players();  // New positions once the round is out
      timer_seen  = plot && (colour == white) && prev_yellow;
      prev_yellow = plot && (colour == yellow);
      if (plot)
        plots++;
      if (timer_seen)
        rounds++;
    end
    repeat (10) @(posedge CLOCK_50);  // Final state must stay quiet
    if (rounds == 0)
    begin
      $display("No play round was seen before game_over");
      errors++;
    end
    $display("Run done: %0d plots, %0d rounds, %0d errors", plots, rounds, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
    $display("Watchdog expired after %0d cycles without game_over", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- vlog.f
verilog/turf_pkg.sv
verilog/game_control.sv
verilog/plot_datapath.sv
verilog/game_timer.sv
verilog/turf_top.sv
bench/turf_properties.sv
bench/turf_tb.sv

//--- Bender.yml
package:
  name: turf_wars

sources:
  - verilog/turf_pkg.sv
  - verilog/game_control.sv
  - verilog/plot_datapath.sv
  - verilog/game_timer.sv
  - verilog/turf_top.sv
  - target: test
    files:
      - bench/turf_properties.sv
      - bench/turf_tb.sv
